// File: Bender.yml
package:
  name: rv32i_core

sources:
  - source/rv32i_pkg.sv
  - source/core_pkg.sv
  - source/instr_q_if.sv
  - source/fetch_decode.sv
  - source/instr_queue.sv
  - source/scoreboard.sv
  - source/exec_pipe.sv
  - source/core_top.sv
  - target: test
    files:
      - tb/core_tb.sv

// File: project.f
source/rv32i_pkg.sv
source/core_pkg.sv
source/instr_q_if.sv
source/fetch_decode.sv
source/instr_queue.sv
source/scoreboard.sv
source/exec_pipe.sv
source/core_top.sv
tb/core_tb.sv

// File: source/core_pkg.sv
// core micro-architecture types: ALU function, execution unit and the decoded queue item
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS
    } alu_fn_t;

    typedef enum logic {
        EXU_ALU,
        EXU_STORE
    } exu_t;

    // decoded instruction as it waits between decode and issue
    typedef struct packed {
        exu_t               exu;
        alu_fn_t            alu_fn;
        logic               has_rd;
        logic               has_rs1;
        logic               has_rs2;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::reg_idx_t rs1;
        rv32i_pkg::reg_idx_t rs2;
        logic               use_imm;
        // already sign-extended, or shifted up for lui
        rv32i_pkg::word_t   imm;
    } queue_item_t;

endpackage

// File: source/core_top.sv
// core top level: fetch/decode, instruction queue and execute joined behind plain memory ports
`timescale 1ns/1ps

module core_top #(
    parameter rv32i_pkg::word_t RESET_PC    = 32'h0000_0060,
    parameter int               QUEUE_DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    output rv32i_pkg::word_t pc,
    output logic             inst_read,
    input  rv32i_pkg::word_t inst_rdata,
    input  logic             inst_resp,
    output rv32i_pkg::word_t data_address,
    output rv32i_pkg::word_t data_wdata,
    output logic             data_write,
    input  logic             data_resp
);

    instr_q_if q_if ();

    fetch_decode #(
        .RESET_PC (RESET_PC)
    ) fetch_decode_i (
        .clk,
        .rst,
        .inst_rdata,
        .inst_resp,
        .pc,
        .inst_read,
        .q (q_if.producer)
    );

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) instr_queue_i (
        .clk,
        .rst,
        .q (q_if.buffer)
    );

    exec_pipe exec_pipe_i (
        .clk,
        .rst,
        .q (q_if.consumer),
        .data_address,
        .data_wdata,
        .data_write,
        .data_resp
    );

endmodule

// File: source/exec_pipe.sv
// back end: issue from the queue, register file, ALU, store port and writeback
`timescale 1ns/1ps

module exec_pipe (
    input  logic             clk,
    input  logic             rst,
    instr_q_if.consumer      q,
    output rv32i_pkg::word_t data_address,
    output rv32i_pkg::word_t data_wdata,
    output logic             data_write,
    input  logic             data_resp
);
    import rv32i_pkg::*;
    import core_pkg::*;

    word_t       rf [1:31];
    queue_item_t head;
    word_t       rs1_val;
    word_t       rs2_val;
    logic        sb_ready;
    logic        issue;
    logic        store_busy;

    logic        ex_valid;
    exu_t        ex_exu;
    alu_fn_t     ex_fn;
    logic        ex_has_rd;
    reg_idx_t    ex_rd;
    word_t       ex_a;
    word_t       ex_b;
    word_t       ex_wdata;
    word_t       ex_result;

    logic        wb_valid;
    reg_idx_t    wb_rd;
    word_t       wb_result;

    assign head    = q.pop_item;
    assign rs1_val = (head.rs1 == '0) ? '0 : rf[head.rs1];
    assign rs2_val = (head.rs2 == '0) ? '0 : rf[head.rs2];

    // a store waiting on the data port freezes EX
    assign store_busy = ex_valid && ex_exu == EXU_STORE && !data_resp;
    assign issue      = !q.empty && sb_ready;
    assign q.pop      = issue;

    scoreboard sb_i (
        .clk,
        .rst,
        .head,
        .head_valid (!q.empty),
        .store_busy,
        .issue,
        .wb_valid,
        .wb_rd,
        .ready      (sb_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (!store_busy) begin
            ex_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (!store_busy) begin
            ex_exu    <= head.exu;
            ex_fn     <= head.alu_fn;
            ex_has_rd <= head.has_rd;
            ex_rd     <= head.rd;
            ex_a      <= rs1_val;
            ex_b      <= head.use_imm ? head.imm : rs2_val;
            ex_wdata  <= rs2_val;
        end
    end

    // stores use the add path for rs1 + imm
    always_comb begin
        case (ex_fn)
            ALU_SUB:  ex_result = ex_a - ex_b;
            ALU_SLL:  ex_result = ex_a << ex_b[4:0];
            ALU_SLT:  ex_result = {31'b0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU: ex_result = {31'b0, ex_a < ex_b};
            ALU_XOR:  ex_result = ex_a ^ ex_b;
            ALU_SRL:  ex_result = ex_a >> ex_b[4:0];
            ALU_SRA:  ex_result = word_t'($signed(ex_a) >>> ex_b[4:0]);
            ALU_OR:   ex_result = ex_a | ex_b;
            ALU_AND:  ex_result = ex_a & ex_b;
            ALU_PASS: ex_result = ex_b;
            default:  ex_result = ex_a + ex_b;
        endcase
    end

    assign data_write   = ex_valid && ex_exu == EXU_STORE;
    assign data_address = ex_result;
    assign data_wdata   = ex_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid && ex_has_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd     <= ex_rd;
        wb_result <= ex_result;
    end

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            rf[wb_rd] <= wb_result;
        end
    end

    a_store_held: assert property (
        @(posedge clk) disable iff (rst)
        data_write && !data_resp |=>
            data_write && $stable(data_address) && $stable(data_wdata)
    ) else $error("store changed while waiting for data_resp");

endmodule

// File: source/fetch_decode.sv
// front end: sequential fetch over the instruction port and decode into queue items
`timescale 1ns/1ps

module fetch_decode #(
    parameter rv32i_pkg::word_t RESET_PC = 32'h0000_0060
) (
    input  logic             clk,
    input  logic             rst,
    input  rv32i_pkg::word_t inst_rdata,
    input  logic             inst_resp,
    output rv32i_pkg::word_t pc,
    output logic             inst_read,
    instr_q_if.producer      q
);
    import rv32i_pkg::*;
    import core_pkg::*;

    instr_u      ins;
    queue_item_t item;
    logic        legal;
    logic        fire;

    function automatic alu_fn_t alu_fn_of(input logic [2:0] funct3, input logic alt);
        alu_fn_t fn;
        case (funct3)
            F3_ADD_SUB: fn = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     fn = ALU_SLL;
            F3_SLT:     fn = ALU_SLT;
            F3_SLTU:    fn = ALU_SLTU;
            F3_XOR:     fn = ALU_XOR;
            F3_SRL_SRA: fn = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      fn = ALU_OR;
            default:    fn = ALU_AND;
        endcase
        return fn;
    endfunction

    // full cannot rise while a request waits, since only a completed fetch pushes
    assign inst_read = ~q.full;
    assign fire = inst_read & inst_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (fire) begin
            pc <= pc + 32'd4;
        end
    end

    assign ins = inst_rdata;

    always_comb begin
        item         = '0;
        item.exu     = EXU_ALU;
        item.alu_fn  = ALU_ADD;
        item.rd      = ins.r.rd;
        item.rs1     = ins.r.rs1;
        item.rs2     = ins.r.rs2;
        item.imm     = {{20{ins.i.imm[11]}}, ins.i.imm};
        legal        = 1'b0;
        case (ins.r.opcode)
            OP_REG: begin
                legal        = 1'b1;
                item.has_rd  = 1'b1;
                item.has_rs1 = 1'b1;
                item.has_rs2 = 1'b1;
                // funct7 bit 5 picks sub and sra
                item.alu_fn  = alu_fn_of(ins.r.funct3, ins.r.funct7[5]);
            end
            OP_IMM: begin
                legal        = 1'b1;
                item.has_rd  = 1'b1;
                item.has_rs1 = 1'b1;
                item.use_imm = 1'b1;
                item.alu_fn  = alu_fn_of(ins.r.funct3,
                                         ins.r.funct3 == F3_SRL_SRA && ins.r.funct7[5]);
            end
            OP_LUI: begin
                legal        = 1'b1;
                item.has_rd  = 1'b1;
                item.use_imm = 1'b1;
                item.alu_fn  = ALU_PASS;
                item.imm     = {ins.i.imm, ins.i.rs1, ins.i.funct3, 12'b0};
            end
            OP_STORE: begin
                legal        = ins.s.funct3 == F3_SW;
                item.exu     = EXU_STORE;
                item.has_rs1 = 1'b1;
                item.has_rs2 = 1'b1;
                item.use_imm = 1'b1;
                item.imm     = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
            end
            default: legal = 1'b0;
        endcase
    end

    // nops and other x0 writes never reach the queue
    assign q.push      = fire & legal & (item.exu == EXU_STORE || item.rd != '0);
    assign q.push_item = item;

    a_pc_held: assert property (
        @(posedge clk) disable iff (rst)
        inst_read && !inst_resp |=> inst_read && $stable(pc)
    ) else $error("fetch request dropped or pc changed while a fetch was waiting");

endmodule

// File: source/instr_q_if.sv
// push and pop sides of the decoded instruction queue, shared by decode, queue and issue
`timescale 1ns/1ps

interface instr_q_if;
    import core_pkg::*;

    logic        push;
    logic        full;
    queue_item_t push_item;
    logic        pop;
    logic        empty;
    // valid whenever empty is low
    queue_item_t pop_item;

    modport producer (output push, output push_item, input full);

    modport buffer (
        input  push,
        input  push_item,
        input  pop,
        output full,
        output empty,
        output pop_item
    );

    modport consumer (output pop, input empty, input pop_item);

endinterface

// File: source/instr_queue.sv
// circular FIFO of decoded instructions between decode and issue
`timescale 1ns/1ps

module instr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    instr_q_if.buffer q
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    queue_item_t      mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({q.push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q.push) begin
            mem[wr_ptr] <= q.push_item;
        end
    end

    assign q.full     = count == (PTR_W + 1)'(QUEUE_DEPTH);
    assign q.empty    = count == '0;
    assign q.pop_item = mem[rd_ptr];

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) q.push |-> !q.full
    ) else $error("push into a full instruction queue");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) q.pop |-> !q.empty
    ) else $error("pop from an empty instruction queue");

endmodule

// File: source/rv32i_pkg.sv
// RV32I encodings shared by decode and the testbench: word types, instruction views, opcodes
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    // one fetched word, read through whichever format the opcode implies
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } instr_u;

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // word store, the only width kept
    localparam logic [2:0] F3_SW      = 3'b010;

    // addi x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

endpackage

// File: source/scoreboard.sv
// per-register busy tracking that decides when the queue head may issue
`timescale 1ns/1ps

module scoreboard (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::queue_item_t head,
    input  logic                head_valid,
    input  logic                store_busy,
    input  logic                issue,
    input  logic                wb_valid,
    input  rv32i_pkg::reg_idx_t wb_rd,
    output logic                ready
);
    import core_pkg::*;

    logic [31:0] busy;
    logic        rs1_hazard;
    logic        rs2_hazard;
    logic        rd_hazard;

    assign rs1_hazard = head.has_rs1 & busy[head.rs1];
    assign rs2_hazard = head.has_rs2 & busy[head.rs2];
    // waw, so an older write cannot land after a younger one
    assign rd_hazard  = head.has_rd & busy[head.rd];

    assign ready = head_valid & ~store_busy & ~rs1_hazard & ~rs2_hazard & ~rd_hazard;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            // x0 writers are dropped in decode and never issue
            if (issue && head.has_rd && head.exu != EXU_STORE) begin
                busy[head.rd] <= 1'b1;
            end
        end
    end

    a_x0_never_busy: assert property (
        @(posedge clk) disable iff (rst) !busy[0]
    ) else $error("x0 marked busy in the scoreboard");

endmodule

// File: tb/core_tb.sv
// testbench for core_top: runs the program from the input file and checks every store
`timescale 1ns/1ps

module core_tb;
    import rv32i_pkg::*;

    localparam int    PERIOD      = 100;
    localparam int    MAX_DELAY   = 3;
    localparam int    DRAIN       = 8;
    localparam word_t RESET_PC    = 32'h0000_0060;
    localparam int    QUEUE_DEPTH = 8;
    localparam logic [31:0] SEED  = 32'hb0be_3261;

    logic  clk;
    logic  rst;
    word_t pc;
    logic  inst_read;
    word_t inst_rdata;
    logic  inst_resp;
    word_t data_address;
    word_t data_wdata;
    logic  data_write;
    logic  data_resp;

    word_t       prog[$];
    word_t       exp_addr[$];
    word_t       exp_data[$];
    logic [31:0] lfsr;
    int          store_idx;
    logic        fetch_wait;
    int          fetch_left;
    word_t       fetch_pc;
    logic        store_wait;
    int          store_left;
    word_t       held_addr;
    word_t       held_data;
    int          timeout;

    core_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (
        .clk,
        .rst,
        .pc,
        .inst_read,
        .inst_rdata,
        .inst_resp,
        .data_address,
        .data_wdata,
        .data_write,
        .data_resp
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    // galois lfsr, one step per delay bit
    function automatic logic [1:0] random_delay();
        logic [1:0] d;
        d = '0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            d = {d[0], lfsr[0]};
        end
        return d;
    endfunction

    function automatic word_t read_program(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || idx >= prog.size()) begin
            return NOP_WORD;
        end
        return prog[idx];
    endfunction

    task automatic load_program();
        int          fd;
        int          n;
        string       line;
        string       tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tb/program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/program_input.txt");
            fail_run();
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s %h %h", tag, a, b);
                if (n >= 2 && tag == "P") begin
                    prog.push_back(a);
                end else if (n == 3 && tag == "S") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // instruction memory with a random response delay per request
    task automatic serve_fetch();
        inst_resp = 1'b0;
        if (inst_read) begin
            if (!fetch_wait) begin
                fetch_wait = 1'b1;
                fetch_left = random_delay();
                fetch_pc   = pc;
            end else begin
                check_equal("pc", pc, fetch_pc);
            end
            if (fetch_left == 0) begin
                inst_rdata = read_program(pc);
                inst_resp  = 1'b1;
                fetch_wait = 1'b0;
            end else begin
                fetch_left--;
            end
        end
    endtask

    task automatic serve_store();
        data_resp = 1'b0;
        if (data_write) begin
            if (!store_wait) begin
                store_wait = 1'b1;
                store_left = random_delay();
                held_addr  = data_address;
                held_data  = data_wdata;
            end else begin
                check_equal("data_address", data_address, held_addr);
                check_equal("data_wdata", data_wdata, held_data);
            end
            if (store_left != 0) begin
                store_left--;
            end else if (store_idx >= exp_addr.size()) begin
                $display("a store to %h appeared after the expected sequence", data_address);
                fail_run();
            end else begin
                check_equal("data_address", data_address, exp_addr[store_idx]);
                check_equal("data_wdata", data_wdata, exp_data[store_idx]);
                store_idx++;
                data_resp  = 1'b1;
                store_wait = 1'b0;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst_rdata = '0;
        inst_resp  = 1'b0;
        data_resp  = 1'b0;
        lfsr       = SEED;
        store_idx  = 0;
        fetch_wait = 1'b0;
        fetch_left = 0;
        store_wait = 1'b0;
        store_left = 0;
        load_program();
        timeout = (prog.size() + exp_addr.size()) * (MAX_DELAY + 4) * PERIOD;
        fork
            begin
                #(timeout);
                $display("timeout: only %0d of %0d expected stores appeared",
                         store_idx, exp_addr.size());
                fail_run();
            end
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // reset values hold until the first edge without reset
        check_equal("inst_read", inst_read, 1'b1);
        check_equal("pc", pc, RESET_PC);
        check_equal("data_write", data_write, 1'b0);
        while (store_idx < exp_addr.size()) begin
            serve_fetch();
            serve_store();
            @(negedge clk);
        end
        // a few more cycles so a repeated store would show up
        repeat (DRAIN) begin
            serve_fetch();
            serve_store();
            @(negedge clk);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: tb/program_input.txt
# P <word>: program word, consecutive addresses from the reset pc
# S <address> <data>: expected store, in program order
P 10000093  # addi x1, x0, 0x100
P ffb00113  # addi x2, x0, -5
P 0f014213  # xori x4, x2, 0x0f0
P 0040a023  # sw   x4, 0(x1)
P 123452b7  # lui  x5, 0x12345
P 67828293  # addi x5, x5, 0x678
P 00429313  # slli x6, x5, 4
P 0060a223  # sw   x6, 4(x1)
P ffc12193  # slti x3, x2, -4
P 01c15413  # srli x8, x2, 28
P 008125b3  # slt  x11, x2, x8
P 00243633  # sltu x12, x8, x2
P 00b184b3  # add  x9, x3, x11
P 00c484b3  # add  x9, x9, x12
P 0090a423  # sw   x9, 8(x1)
P 40540533  # sub  x10, x8, x5
P 40355733  # sra  x14, x10, x3
P 006777b3  # and  x15, x14, x6
P 00f0a623  # sw   x15, 12(x1)
P 00710013  # addi x0, x2, 7
P 00628033  # add  x0, x5, x6
P 0000a823  # sw   x0, 16(x1)
P 00a0aa23  # sw   x10, 20(x1)
S 00000100 ffffff0b
S 00000104 23456780
S 00000108 00000003
S 0000010c 22454480
S 00000110 00000000
S 00000114 edcba997
